/* design/hit_shader.sv */
// Nearest-hit selector and ambient plus diffuse shader with registered colour output
`default_nettype none

module hit_shader (
    input  logic         clk_i,
    input  logic         reset_i,
    input  rt_pkg::ray_t ray_i,
    input  rt_pkg::hit_t hits_i [rt_pkg::SPHERE_COUNT],
    output rt_pkg::rgb_t rgb_o,
    output logic         output_valid_o
);

    logic [$clog2(rt_pkg::SPHERE_COUNT)-1:0] near_idx;
    logic            near_hit;
    rt_pkg::q16_t    near_t;
    rt_pkg::sphere_t near_sphere;
    rt_pkg::vec3_t   point;
    rt_pkg::vec3_t   normal;
    rt_pkg::q16_t    ndotl;
    rt_pkg::q16_t    diff_raw;
    logic [4:0]      diffuse;
    rt_pkg::rgb_t    shade;
    rt_pkg::rgb_t    rgb_d;

    // Ambient eighth of the base colour plus the light-tinted diffuse part
    function automatic logic [7:0] shade_channel(
        input logic [7:0] base,
        input logic [7:0] light,
        input logic [4:0] diff
    );
        int tinted;
        int sum;
        tinted = (int'(base) * int'(light)) >>> 8;
        sum = (int'(base) >>> 3) + ((tinted * int'(diff)) >>> 4);
        return (sum > 255) ? 8'd255 : sum[7:0];
    endfunction

    always_comb begin
        near_hit = 1'b0;
        near_t = '0;
        near_idx = '0;
        for (int k = 0; k < rt_pkg::SPHERE_COUNT; k++) begin
            // Strict compare keeps the lower index on a tie
            if (hits_i[k].hit && (!near_hit || hits_i[k].t < near_t)) begin
                near_hit = 1'b1;
                near_t = hits_i[k].t;
                near_idx = k[$bits(near_idx)-1:0];
            end
        end
    end

    assign near_sphere = rt_pkg::SPHERES[near_idx];

    assign point = '{
        x: rt_pkg::q16_mul(near_t, ray_i.dir.x),
        y: rt_pkg::q16_mul(near_t, ray_i.dir.y),
        z: rt_pkg::q16_mul(near_t, ray_i.dir.z)
    };

    // Stored reciprocal radius gives a unit normal without a divide
    assign normal = '{
        x: rt_pkg::q16_mul(point.x - near_sphere.centre.x, near_sphere.inv_radius),
        y: rt_pkg::q16_mul(point.y - near_sphere.centre.y, near_sphere.inv_radius),
        z: rt_pkg::q16_mul(point.z - near_sphere.centre.z, near_sphere.inv_radius)
    };

    assign ndotl = rt_pkg::q16_dot3(normal, rt_pkg::LIGHT_DIR);
    assign diff_raw = rt_pkg::q16_mul(ndotl, rt_pkg::LIGHT_INTENSITY) >>> 12;

    always_comb begin
        if (diff_raw < 32'sd0) begin
            diffuse = '0;
        end else if (diff_raw > rt_pkg::DIFFUSE_MAX) begin
            diffuse = 5'(rt_pkg::DIFFUSE_MAX);
        end else begin
            diffuse = diff_raw[4:0];
        end
    end

    assign shade = '{
        r: shade_channel(near_sphere.colour.r, rt_pkg::LIGHT_COLOR.r, diffuse),
        g: shade_channel(near_sphere.colour.g, rt_pkg::LIGHT_COLOR.g, diffuse),
        b: shade_channel(near_sphere.colour.b, rt_pkg::LIGHT_COLOR.b, diffuse)
    };

    assign rgb_d = near_hit ? shade : rt_pkg::BG_COLOR;

    always_ff @(posedge clk_i) begin
        rgb_o <= rgb_d;
        if (reset_i) begin
            output_valid_o <= 1'b0;
        end else begin
            output_valid_o <= ray_i.valid;
        end
    end

endmodule

`default_nettype wire

/* design/ray_gen.sv */
// Eye-ray generator that maps a screen pixel to an unnormalized view direction
`default_nettype none

module ray_gen (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           pixel_valid_i,
    input  rt_pkg::pixel_t pixel_i,
    output rt_pkg::ray_t   ray_o
);

    rt_pkg::q16_t  centred_x;
    rt_pkg::q16_t  centred_y;
    rt_pkg::vec3_t dir_d;

    // Screen y grows downward, world y grows upward
    assign centred_x = $signed({22'd0, pixel_i.x}) - rt_pkg::SCREEN_CX;
    assign centred_y = rt_pkg::SCREEN_CY - $signed({23'd0, pixel_i.y});

    assign dir_d = '{
        x: centred_x <<< rt_pkg::DIR_SHIFT,
        y: centred_y <<< rt_pkg::DIR_SHIFT,
        z: rt_pkg::FOCAL_Z
    };

    always_ff @(posedge clk_i) begin
        ray_o.dir <= dir_d;
        ray_o.pixel <= pixel_i;
        if (reset_i) begin
            ray_o.valid <= 1'b0;
        end else begin
            ray_o.valid <= pixel_valid_i;
        end
    end

endmodule

`default_nettype wire

/* design/raytracer_top.sv */
// Three-stage ray tracer top: eye ray, parallel sphere tests, nearest-hit shading
`default_nettype none

module raytracer_top (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           pixel_valid_i,
    input  rt_pkg::pixel_t pixel_i,
    output rt_pkg::rgb_t   rgb_o,
    output logic           output_valid_o
);

    rt_pkg::ray_t ray_eye;
    rt_pkg::ray_t ray_hit;
    rt_pkg::hit_t hits [rt_pkg::SPHERE_COUNT];

    ray_gen u_ray_gen (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .pixel_valid_i (pixel_valid_i),
        .pixel_i       (pixel_i),
        .ray_o         (ray_eye)
    );

    // All units see the same ray, instance 0 carries it on to the shader
    for (genvar k = 0; k < rt_pkg::SPHERE_COUNT; k++) begin : g_sphere
        if (k == 0) begin : g_lead
            sphere_intersect u_isect (
                .clk_i    (clk_i),
                .reset_i  (reset_i),
                .ray_i    (ray_eye),
                .sphere_i (rt_pkg::SPHERES[k]),
                .hit_o    (hits[k]),
                .ray_o    (ray_hit)
            );
        end else begin : g_rest
            sphere_intersect u_isect (
                .clk_i    (clk_i),
                .reset_i  (reset_i),
                .ray_i    (ray_eye),
                .sphere_i (rt_pkg::SPHERES[k]),
                .hit_o    (hits[k]),
                .ray_o    ()
            );
        end
    end

    hit_shader u_hit_shader (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ray_i          (ray_hit),
        .hits_i         (hits),
        .rgb_o          (rgb_o),
        .output_valid_o (output_valid_o)
    );

endmodule

`default_nettype wire

/* design/rt_pkg.sv */
// Renderer package with Q16.16 types, scene table, light setup and fixed-point arithmetic
`default_nettype none

package rt_pkg;

    localparam int SPHERE_COUNT = 3;

    typedef logic signed [31:0] q16_t;

    typedef struct packed {
        q16_t x;
        q16_t y;
        q16_t z;
    } vec3_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } pixel_t;

    typedef struct packed {
        logic   valid;
        vec3_t  dir;
        pixel_t pixel;
    } ray_t;

    typedef struct packed {
        logic hit;
        q16_t t;
    } hit_t;

    typedef struct packed {
        vec3_t centre;
        q16_t  radius;
        q16_t  inv_radius;
        rgb_t  colour;
    } sphere_t;

    // Scene kept within |C| of about 1.2 so that b*b and a*c stay inside Q16 range
    localparam sphere_t SPHERES [SPHERE_COUNT] = '{
        '{centre: '{x: 32'sd0, y: 32'sd0, z: 32'sd65536},
          radius: 32'sd13107, inv_radius: 32'sd327680,
          colour: '{r: 8'd255, g: 8'd64, b: 8'd64}},
        '{centre: '{x: -32'sd19661, y: 32'sd6554, z: 32'sd72090},
          radius: 32'sd13107, inv_radius: 32'sd327680,
          colour: '{r: 8'd64, g: 8'd255, b: 8'd64}},
        '{centre: '{x: 32'sd22938, y: -32'sd9830, z: 32'sd68813},
          radius: 32'sd9830, inv_radius: 32'sd436907,
          colour: '{r: 8'd64, g: 8'd64, b: 8'd255}}
    };

    // Unit vector toward the light, from upper left and in front of the spheres
    localparam vec3_t LIGHT_DIR = '{x: -32'sd37837, y: 32'sd37837, z: -32'sd37837};
    localparam q16_t  LIGHT_INTENSITY = 32'sd65536;
    localparam rgb_t  LIGHT_COLOR = '{r: 8'd255, g: 8'd255, b: 8'd255};
    localparam rgb_t  BG_COLOR = '{r: 8'd0, g: 8'd0, b: 8'd32};

    localparam int   SCREEN_CX = 320;
    localparam int   SCREEN_CY = 240;
    localparam q16_t FOCAL_Z = 32'sd6553600;
    localparam int   DIR_SHIFT = 14;
    localparam int   DIFFUSE_MAX = 16;

    // Product with rounding on the dropped fraction bits
    function automatic q16_t q16_mul(input q16_t a, input q16_t b);
        logic signed [63:0] prod;
        prod = a * b + 64'sd32768;
        return prod[47:16];
    endfunction

    function automatic q16_t q16_div(input q16_t a, input q16_t b);
        logic signed [63:0] num;
        logic signed [63:0] quot;
        if (b == 32'sd0) begin
            return (a >= 32'sd0) ? 32'sh7fff_ffff : -32'sh7fff_ffff;
        end
        num = 64'(a) <<< 16;
        quot = num / b;
        return quot[31:0];
    endfunction

    // Each product is truncated before the sum
    function automatic q16_t q16_dot3(input vec3_t a, input vec3_t b);
        logic signed [63:0] px;
        logic signed [63:0] py;
        logic signed [63:0] pz;
        px = (a.x * b.x) >>> 16;
        py = (a.y * b.y) >>> 16;
        pz = (a.z * b.z) >>> 16;
        return px[31:0] + py[31:0] + pz[31:0];
    endfunction

    // Restoring square root over 24 digit pairs of the Q32 operand
    function automatic q16_t q16_sqrt(input q16_t a);
        logic [63:0] v;
        logic [63:0] rem;
        logic [63:0] root;
        logic [63:0] trial;
        if (a <= 32'sd0) begin
            return '0;
        end
        v = {16'h0, a, 16'h0};
        rem = '0;
        root = '0;
        for (int i = 23; i >= 0; i--) begin
            rem = (rem << 2) | ((v >> (2 * i)) & 64'd3);
            trial = (root << 2) | 64'd1;
            if (rem >= trial) begin
                rem = rem - trial;
                root = (root << 1) | 64'd1;
            end else begin
                root = root << 1;
            end
        end
        return root[31:0];
    endfunction

endpackage

`default_nettype wire

/* design/sphere_intersect.sv */
// Ray-sphere intersection unit solving the quadratic and registering the nearest positive root
`default_nettype none

module sphere_intersect (
    input  logic            clk_i,
    input  logic            reset_i,
    input  rt_pkg::ray_t    ray_i,
    input  rt_pkg::sphere_t sphere_i,
    output rt_pkg::hit_t    hit_o,
    output rt_pkg::ray_t    ray_o
);

    rt_pkg::vec3_t offset;
    rt_pkg::q16_t  coef_a;
    rt_pkg::q16_t  half_b;
    rt_pkg::q16_t  coef_c;
    rt_pkg::q16_t  disc;
    rt_pkg::q16_t  root;
    rt_pkg::q16_t  t_near;
    rt_pkg::q16_t  t_far;
    logic          hit_d;
    rt_pkg::q16_t  t_d;

    // Origin sits at zero so the offset is the negated centre
    assign offset = '{
        x: -sphere_i.centre.x,
        y: -sphere_i.centre.y,
        z: -sphere_i.centre.z
    };

    assign coef_a = rt_pkg::q16_dot3(ray_i.dir, ray_i.dir);
    assign half_b = rt_pkg::q16_dot3(offset, ray_i.dir);
    assign coef_c = rt_pkg::q16_dot3(offset, offset)
                  - rt_pkg::q16_mul(sphere_i.radius, sphere_i.radius);
    assign disc = rt_pkg::q16_mul(half_b, half_b) - rt_pkg::q16_mul(coef_a, coef_c);

    // sqrt gives zero on a negative discriminant, which is rejected below anyway
    assign root = rt_pkg::q16_sqrt(disc);
    assign t_near = rt_pkg::q16_div(-half_b - root, coef_a);
    assign t_far = rt_pkg::q16_div(-half_b + root, coef_a);

    always_comb begin
        hit_d = 1'b0;
        t_d = '0;
        if (disc >= 32'sd0 && coef_a != 32'sd0) begin
            if (t_near > 32'sd0 && t_far > 32'sd0) begin
                hit_d = 1'b1;
                t_d = (t_near < t_far) ? t_near : t_far;
            end else if (t_near > 32'sd0) begin
                hit_d = 1'b1;
                t_d = t_near;
            end else if (t_far > 32'sd0) begin
                // Only the far root is ahead of the eye
                hit_d = 1'b1;
                t_d = t_far;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        hit_o <= '{hit: hit_d, t: t_d};
        ray_o.dir <= ray_i.dir;
        ray_o.pixel <= ray_i.pixel;
        if (reset_i) begin
            ray_o.valid <= 1'b0;
        end else begin
            ray_o.valid <= ray_i.valid;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the ray tracer testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module raytracer_tb \
    -o raytracer_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/raytracer_sim > sim.log 2>&1 || echo "Simulation stopped with an error" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

/* sources.f */
+incdir+tb
design/rt_pkg.sv
design/ray_gen.sv
design/sphere_intersect.sv
design/hit_shader.sv
design/raytracer_top.sv
tb/raytracer_checker.sv
tb/raytracer_tb.sv

/* tb/raytracer_checker.sv */
// Valid-timing checker for the ray tracer top, bound into the DUT
`default_nettype none

module raytracer_checker (
    input logic clk_i,
    input logic reset_i,
    input logic pixel_valid_i,
    input logic output_valid_i
);

    // Each pixel leaves the pipeline exactly three cycles after it enters
    a_latency_fwd: assert property (@(posedge clk_i) disable iff (reset_i)
        pixel_valid_i |-> ##3 output_valid_i)
        else $error("output_valid_o missing three cycles after pixel_valid_i");

    a_latency_back: assert property (@(posedge clk_i) disable iff (reset_i)
        output_valid_i |-> $past(pixel_valid_i, 3))
        else $error("output_valid_o without a pixel_valid_i three cycles before");

    a_reset_low: assert property (@(posedge clk_i) reset_i |=> !output_valid_i)
        else $error("output_valid_o high while reset is applied");

    // Second cycle after release still has an empty pipeline
    a_release_low: assert property (@(posedge clk_i) $fell(reset_i) |=> !output_valid_i)
        else $error("output_valid_o high in the cycle after reset release");

endmodule

bind raytracer_top raytracer_checker u_checker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .pixel_valid_i  (pixel_valid_i),
    .output_valid_i (output_valid_o)
);

`default_nettype wire

/* tb/raytracer_model.svh */
// Reference model of the renderer that predicts the nearest sphere and the pixel colour
`ifndef RAYTRACER_MODEL_SVH
`define RAYTRACER_MODEL_SVH

function automatic rt_pkg::vec3_t eye_ray_dir(input int px, input int py);
    rt_pkg::vec3_t d;
    d.x = rt_pkg::q16_t'(px - rt_pkg::SCREEN_CX) <<< rt_pkg::DIR_SHIFT;
    d.y = rt_pkg::q16_t'(rt_pkg::SCREEN_CY - py) <<< rt_pkg::DIR_SHIFT;
    d.z = rt_pkg::FOCAL_Z;
    return d;
endfunction

// Distance along the ray to the first surface ahead of the eye
function automatic rt_pkg::hit_t sphere_hit(input rt_pkg::vec3_t d, input rt_pkg::sphere_t s);
    rt_pkg::vec3_t l;
    rt_pkg::q16_t  a;
    rt_pkg::q16_t  hb;
    rt_pkg::q16_t  c;
    rt_pkg::q16_t  disc;
    rt_pkg::q16_t  sq;
    rt_pkg::q16_t  t0;
    rt_pkg::q16_t  t1;
    rt_pkg::hit_t  h;
    l = '{x: -s.centre.x, y: -s.centre.y, z: -s.centre.z};
    a = rt_pkg::q16_dot3(d, d);
    hb = rt_pkg::q16_dot3(l, d);
    c = rt_pkg::q16_dot3(l, l) - rt_pkg::q16_mul(s.radius, s.radius);
    disc = rt_pkg::q16_mul(hb, hb) - rt_pkg::q16_mul(a, c);
    h = '{hit: 1'b0, t: '0};
    if (disc >= 0 && a != 0) begin
        sq = rt_pkg::q16_sqrt(disc);
        t0 = rt_pkg::q16_div(-hb - sq, a);
        t1 = rt_pkg::q16_div(-hb + sq, a);
        if (t0 > 0 && (t1 <= 0 || t0 <= t1)) begin
            h = '{hit: 1'b1, t: t0};
        end else if (t1 > 0) begin
            h = '{hit: 1'b1, t: t1};
        end
    end
    return h;
endfunction

// Index of the nearest sphere or -1 on a miss
function automatic int nearest_sphere(input rt_pkg::vec3_t d);
    rt_pkg::hit_t h;
    rt_pkg::q16_t best_t;
    int           best;
    best = -1;
    best_t = '0;
    for (int k = 0; k < rt_pkg::SPHERE_COUNT; k++) begin
        h = sphere_hit(d, rt_pkg::SPHERES[k]);
        if (h.hit && (best < 0 || h.t < best_t)) begin
            best = k;
            best_t = h.t;
        end
    end
    return best;
endfunction

function automatic logic [7:0] shaded_channel(input int base, input int light, input int diff);
    int v;
    v = base / 8 + (((base * light) / 256) * diff) / 16;
    return (v > 255) ? 8'd255 : 8'(v);
endfunction

function automatic rt_pkg::rgb_t pixel_colour(input rt_pkg::vec3_t d, input int idx);
    rt_pkg::sphere_t s;
    rt_pkg::hit_t    h;
    rt_pkg::vec3_t   n;
    rt_pkg::rgb_t    col;
    int              diff;
    col = '{r: 8'd0, g: 8'd0, b: 8'd32};
    if (idx >= 0) begin
        s = rt_pkg::SPHERES[idx];
        h = sphere_hit(d, s);
        n.x = rt_pkg::q16_mul(rt_pkg::q16_mul(h.t, d.x) - s.centre.x, s.inv_radius);
        n.y = rt_pkg::q16_mul(rt_pkg::q16_mul(h.t, d.y) - s.centre.y, s.inv_radius);
        n.z = rt_pkg::q16_mul(rt_pkg::q16_mul(h.t, d.z) - s.centre.z, s.inv_radius);
        diff = rt_pkg::q16_mul(rt_pkg::q16_dot3(n, rt_pkg::LIGHT_DIR),
                               rt_pkg::LIGHT_INTENSITY) >>> 12;
        if (diff < 0) begin
            diff = 0;
        end else if (diff > rt_pkg::DIFFUSE_MAX) begin
            diff = rt_pkg::DIFFUSE_MAX;
        end
        col.r = shaded_channel(s.colour.r, rt_pkg::LIGHT_COLOR.r, diff);
        col.g = shaded_channel(s.colour.g, rt_pkg::LIGHT_COLOR.g, diff);
        col.b = shaded_channel(s.colour.b, rt_pkg::LIGHT_COLOR.b, diff);
    end
    return col;
endfunction

`endif

/* tb/raytracer_tb.sv */
// Ray tracer testbench with a directed pixel table, a seeded random stream and a scoreboard
`default_nettype none

module raytracer_tb;

    typedef struct packed {
        logic [9:0]        x;
        logic [8:0]        y;
        logic signed [7:0] cls;
    } stim_t;

    typedef struct packed {
        rt_pkg::rgb_t   rgb;
        rt_pkg::pixel_t pixel;
        logic [31:0]    cycle;
    } expect_t;

    localparam int TABLE_LEN = 12;
    localparam int RANDOM_COUNT = 200;
    localparam int WATCHDOG_TIME = (TABLE_LEN + RANDOM_COUNT + 50) * 10 * 2;

    // Corners, sphere centres, an overlap of spheres 0 and 1, and silhouette edges of sphere 0
    localparam stim_t STIM_TABLE [TABLE_LEN] = '{
        '{x: 10'd0,   y: 9'd0,   cls: -8'sd1},
        '{x: 10'd639, y: 9'd0,   cls: -8'sd1},
        '{x: 10'd0,   y: 9'd479, cls: -8'sd1},
        '{x: 10'd639, y: 9'd479, cls: -8'sd1},
        '{x: 10'd320, y: 9'd240, cls: 8'sd0},
        '{x: 10'd211, y: 9'd204, cls: 8'sd1},
        '{x: 10'd453, y: 9'd297, cls: 8'sd2},
        '{x: 10'd259, y: 9'd220, cls: 8'sd0},
        '{x: 10'd401, y: 9'd240, cls: 8'sd0},
        '{x: 10'd402, y: 9'd240, cls: -8'sd1},
        '{x: 10'd320, y: 9'd159, cls: 8'sd0},
        '{x: 10'd320, y: 9'd158, cls: -8'sd1}
    };

    logic           clk;
    logic           reset;
    logic           pixel_valid;
    rt_pkg::pixel_t pixel;
    rt_pkg::rgb_t   rgb;
    logic           output_valid;

    expect_t     expected_q [$];
    logic [31:0] cycle_count = '0;
    logic [31:0] rng_state = 32'hb171_2cac;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    `include "raytracer_model.svh"

    raytracer_top dut0 (
        .clk_i          (clk),
        .reset_i        (reset),
        .pixel_valid_i  (pixel_valid),
        .pixel_i        (pixel),
        .rgb_o          (rgb),
        .output_valid_o (output_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 32'd1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_output();
        expect_t e;
        if (output_valid) begin
            checks++;
            assert (expected_q.size() > 0) else begin
                $display("Output valid at time %0t with no pixel waiting for it", $time);
                other_errors++;
            end
            if (expected_q.size() > 0) begin
                e = expected_q.pop_front();
                assert (rgb == e.rgb) else begin
                    $display("FAIL %0t: pixel (%0d,%0d) gave rgb %h, expected %h",
                             $time, e.pixel.x, e.pixel.y, rgb, e.rgb);
                    value_errors++;
                end
                assert (cycle_count == e.cycle + 32'd3) else begin
                    $display("FAIL %0t: pixel (%0d,%0d) took %0d cycles, expected 3",
                             $time, e.pixel.x, e.pixel.y, cycle_count - e.cycle);
                    value_errors++;
                end
            end
        end
    endtask

    // Check the output on the falling edge before presenting the next input
    task automatic drive_cycle(input logic valid, input logic [9:0] x, input logic [8:0] y);
        rt_pkg::vec3_t d;
        expect_t       e;
        @(negedge clk);
        check_output();
        pixel_valid = valid;
        pixel = '{x: x, y: y};
        if (valid) begin
            d = eye_ray_dir(int'(x), int'(y));
            e.rgb = pixel_colour(d, nearest_sphere(d));
            e.pixel = pixel;
            e.cycle = cycle_count;
            expected_q.push_back(e);
        end
    endtask

    initial begin
        stim_t      s;
        int         cls;
        logic [9:0] rx;
        logic [8:0] ry;
        reset = 1'b1;
        pixel_valid = 1'b0;
        pixel = '0;
        repeat (10) drive_cycle(1'b0, '0, '0);
        reset = 1'b0;

        for (int i = 0; i < TABLE_LEN; i++) begin
            s = STIM_TABLE[i];
            cls = nearest_sphere(eye_ray_dir(int'(s.x), int'(s.y)));
            checks++;
            assert (cls == int'(s.cls)) else begin
                $display("FAIL %0t: table pixel (%0d,%0d) nearest sphere %0d, expected %0d",
                         $time, s.x, s.y, cls, s.cls);
                value_errors++;
            end
            drive_cycle(1'b1, s.x, s.y);
        end
        repeat (2) drive_cycle(1'b0, '0, '0);

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rng_state = lcg_next(rng_state);
            // About one pixel in eight gets an idle cycle in front of it
            if (rng_state[31:29] == 3'd0) begin
                drive_cycle(1'b0, '0, '0);
            end
            rng_state = lcg_next(rng_state);
            rx = 10'((rng_state >> 8) % 32'd640);
            rng_state = lcg_next(rng_state);
            ry = 9'((rng_state >> 8) % 32'd480);
            drive_cycle(1'b1, rx, ry);
        end

        while (expected_q.size() > 0) begin
            drive_cycle(1'b0, '0, '0);
        end
        repeat (5) drive_cycle(1'b0, '0, '0);

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout at %0t: the pipeline did not drain in time", $time);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
